// File: rx_vectors.txt
# kind len dtype chan fend line flags exp_ck exp_bytes exp_pulses, all hex
# kind 0 frame, 1 link-loss burst of len words, 2 rx_start with base in len, 3 soft reset
# frame flags: bit0 bad checksum, bit1 K flag on first payload word, bit2 sync detect on
# burst flags: bit0 link detect on
2 10000000 0 0 0 0 0 0 0 0
0 0002 3 1 0 012345 0 0 0008 0
0 0008 a 2 1 00beef 0 0 0008 0
0 000a 5 3 0 abcdef 1 1 0010 0
0 0010 f 0 1 000001 0 0 0010 0
0 0006 1 1 0 fedcba 1 1 0008 0
0 0064 7 2 0 001234 0 0 0068 0
0 0020 2 1 1 00ffff 6 0 0020 1
0 000c 4 0 0 000002 2 0 0010 0
2 20000000 0 0 0 0 0 0 0 0
0 000e 9 3 1 777777 0 0 0010 0
1 0064 0 0 0 0 1 0 0 2
1 0014 0 0 0 0 1 0 0 1
1 0096 0 0 0 0 1 0 0 3
1 0032 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0
2 30000000 0 0 0 0 0 0 0 0
0 0012 6 2 0 054321 0 0 0018 0
3 0 0 0 0 0 0 0 0 0

// File: src.f
rx_link_pkg.sv
rx_frame_parser.sv
rx_pack_fifo.sv
rx_dma_ctrl.sv
rx_loss_monitor.sv
tlk2711_rx_link.sv
tb_clk_gen.sv
tb_tlk2711_rx_link.sv

// File: Bender.yml
package:
  name: tlk2711_rx_link

sources:
  - rx_link_pkg.sv
  - rx_frame_parser.sv
  - rx_pack_fifo.sv
  - rx_dma_ctrl.sv
  - rx_loss_monitor.sv
  - tlk2711_rx_link.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_tlk2711_rx_link.sv

// File: tb_tlk2711_rx_link.sv
`timescale 1ns/1ps

module tb_tlk2711_rx_link;

    logic        clk, arst_n, soft_rst, rk_msb, rk_lsb, rx_start, cmd_ack, dma_ready, wr_finish;
    logic        link_ena, sync_ena, cmd_req, dma_valid, rx_int, ck_flag, fend, link_loss;
    logic        sync_loss, loss_int;
    logic [15:0] rxd, frame_len;
    logic [31:0] base_addr, addr_model, lfsr_q = 32'h856baa03;
    logic [47:0] cmd_data;
    logic [63:0] dma_data, exp_beat;
    logic [23:0] frame_num;
    logic [3:0]  dtype;
    logic [1:0]  chan_id;
    logic [31:0] v_kind[$], v_len[$], v_dtype[$], v_chan[$], v_fend[$], v_line[$];
    logic [31:0] v_flags[$], v_ck[$], v_bytes[$], v_pulses[$];
    logic [15:0] exp_q[$], words[$];
    int          val_errs, other_errs, link_cnt, sync_cnt, loss_cnt, fd, limit;
    string       text;

    tb_clk_gen #(.PERIOD_NS(20.0), .RST_CYCLES(8)) u_clk_gen (.o_clk(clk), .o_arst_n(arst_n));

    tlk2711_rx_link #(.HOLDOFF_CYCLES(24'd64)) tlk2711_rx_link_inst (
        .clk(clk), .i_arst_n(arst_n), .i_soft_rst(soft_rst), .i_rk_msb(rk_msb),
        .i_rk_lsb(rk_lsb), .i_rxd(rxd), .i_rx_start(rx_start), .i_rx_base_addr(base_addr),
        .i_wr_cmd_ack(cmd_ack), .i_dma_wr_ready(dma_ready), .i_wr_finish(wr_finish),
        .i_link_loss_detect_ena(link_ena), .i_sync_loss_detect_ena(sync_ena),
        .o_wr_cmd_req(cmd_req), .o_wr_cmd_data(cmd_data), .o_dma_wr_valid(dma_valid),
        .o_dma_wr_data(dma_data), .o_rx_interrupt(rx_int), .o_rx_frame_length(frame_len),
        .o_rx_frame_num(frame_num), .o_rx_data_type(dtype), .o_rx_file_end_flag(fend),
        .o_rx_checksum_flag(ck_flag), .o_rx_channel_id(chan_id), .o_link_loss(link_loss),
        .o_sync_loss(sync_loss), .o_loss_interrupt(loss_int)
    );

    // Taps 32, 22, 2, 1
    function automatic logic take_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] take_word();
        logic [15:0] w;
        for (int i = 0; i < 16; i++) w = {w[14:0], take_bit()};
        return w;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            val_errs++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic send_word(input logic msb, input logic lsb, input logic [15:0] w);
        @(posedge clk);
        rk_msb <= msb;
        rk_lsb <= lsb;
        rxd    <= w;
    endtask

    task automatic check_ctrl_low(input string when);
        check_val({when, " control outputs"}, 64'd0,
                  {cmd_req, dma_valid, rx_int, link_loss, sync_loss, loss_int, ck_flag});
    endtask

    // Request must stay high until ack, data sampled before the address moves on
    task automatic serve_cmd(input logic [15:0] bytes);
        int n;
        n = 0;
        @(negedge clk);
        while (!cmd_req && n < 40) begin
            n++;
            @(negedge clk);
        end
        assert (cmd_req) else begin
            other_errs++;
            $display("Write command request never came");
        end
        check_val("write command", {addr_model, bytes}, cmd_data);
        @(posedge clk) cmd_ack <= 1'b1;
        @(negedge clk) check_val("request held until ack", 1, cmd_req);
        @(posedge clk) cmd_ack <= 1'b0;
        @(negedge clk) check_val("request dropped after ack", 0, cmd_req);
        addr_model = addr_model + bytes;
    endtask

    task automatic run_frame(input int i);
        logic [15:0] len, cks, info;
        int          pads, n;
        // Draw payload away from the edge where dma_ready is stepped
        @(negedge clk);
        len  = v_len[i][15:0];
        info = {1'b0, v_fend[i][0], v_chan[i][1:0], v_dtype[i][3:0], v_line[i][23:16]};
        words = {info, v_line[i][15:0], len};
        for (int k = 0; k < len / 2; k++) words.push_back(take_word());
        cks = 16'd0;
        foreach (words[k]) cks = cks + words[k];
        cks  = cks ^ {15'd0, v_flags[i][0]};
        pads = (4 - (len / 2) % 4) % 4;
        for (int k = 3; k < words.size(); k++) exp_q.push_back(words[k]);
        if (pads > 0) exp_q.push_back(cks);
        if (pads > 1) exp_q.push_back(16'hee11);
        if (pads > 2) exp_q.push_back(16'hee22);
        sync_cnt = 0;
        link_cnt = 0;
        loss_cnt = 0;
        send_word(1'b0, 1'b0, 16'h0000);
        sync_ena <= v_flags[i][2];
        fork
            begin
                send_word(1'b0, 1'b1, 16'hc5bc);
                send_word(1'b1, 1'b1, 16'h5cfb);
                send_word(1'b0, 1'b0, 16'heb90);
                send_word(1'b0, 1'b0, 16'he116);
                foreach (words[k]) send_word(1'b0, k == 3 && v_flags[i][1], words[k]);
                send_word(1'b0, 1'b0, cks);
                send_word(1'b0, 1'b0, 16'hee11);
                send_word(1'b0, 1'b0, 16'hee22);
                // Flag is valid only until the next idle word
                @(negedge clk) check_val("checksum flag", v_ck[i], ck_flag);
            end
            serve_cmd(v_bytes[i][15:0]);
        join
        check_val("frame length", len, frame_len);
        check_val("frame number", v_line[i][23:0], frame_num);
        check_val("data type", v_dtype[i][3:0], dtype);
        check_val("channel id", v_chan[i][1:0], chan_id);
        check_val("file end flag", v_fend[i][0], fend);
        repeat (4) send_word(1'b0, 1'b0, 16'h0000);
        sync_ena <= 1'b0;
        n = 0;
        while (exp_q.size() != 0 && n < 400) begin
            n++;
            @(negedge clk);
        end
        assert (exp_q.size() == 0) else begin
            other_errs++;
            $display("DMA beats of frame %0d never drained", i);
        end
        check_val("sync loss pulses", v_pulses[i], sync_cnt);
        check_val("link loss pulses", 0, link_cnt);
        check_val("loss interrupt pulses", v_pulses[i], loss_cnt);
        // Interrupt only for the first finish after a frame
        @(negedge clk) check_val("interrupt before finish", 0, rx_int);
        for (int k = 0; k < 2; k++) begin
            @(posedge clk) wr_finish <= 1'b1;
            @(negedge clk) check_val("interrupt on finish", k == 0, rx_int);
            @(posedge clk) wr_finish <= 1'b0;
        end
    endtask

    task automatic run_link_burst(input int i);
        send_word(1'b0, 1'b0, 16'h0000);
        link_ena <= v_flags[i][0];
        link_cnt = 0;
        sync_cnt = 0;
        loss_cnt = 0;
        repeat (v_len[i]) send_word(1'b1, 1'b1, 16'hffff);
        repeat (4) send_word(1'b0, 1'b0, 16'h0000);
        @(negedge clk);
        check_val("link loss pulses", v_pulses[i], link_cnt);
        check_val("sync loss pulses", 0, sync_cnt);
        check_val("loss interrupt pulses", v_pulses[i], loss_cnt);
        @(posedge clk) link_ena <= 1'b0;
    endtask

    // Header up to the length word leaves the request pending for the reset
    task automatic soft_reset_mid_frame();
        send_word(1'b0, 1'b0, 16'h0000);
        send_word(1'b0, 1'b1, 16'hc5bc);
        send_word(1'b1, 1'b1, 16'h5cfb);
        send_word(1'b0, 1'b0, 16'heb90);
        send_word(1'b0, 1'b0, 16'he116);
        send_word(1'b0, 1'b0, 16'h0000);
        send_word(1'b0, 1'b0, 16'h0000);
        send_word(1'b0, 1'b0, 16'h0010);
        send_word(1'b0, 1'b0, 16'h0000);
        @(negedge clk) check_val("request before soft reset", 1, cmd_req);
        @(posedge clk) soft_rst <= 1'b1;
        @(posedge clk) soft_rst <= 1'b0;
        @(negedge clk) check_ctrl_low("after soft reset");
    endtask

    always @(posedge clk) dma_ready <= take_bit();

    always @(negedge clk) begin
        link_cnt = link_cnt + (arst_n && link_loss);
        sync_cnt = sync_cnt + (arst_n && sync_loss);
        loss_cnt = loss_cnt + (arst_n && loss_int);
        if (arst_n && dma_valid) begin
            if (exp_q.size() < 4) begin
                other_errs++;
                $display("DMA beat came with no payload pending");
            end else begin
                exp_beat = {exp_q[3], exp_q[2], exp_q[1], exp_q[0]};
                repeat (4) void'(exp_q.pop_front());
                check_val("dma beat", exp_beat, dma_data);
            end
        end
    end

    initial begin
        logic [31:0] f [10];
        int          n_read;
        {soft_rst, rk_msb, rk_lsb, rx_start, cmd_ack, dma_ready, wr_finish} = '0;
        {link_ena, sync_ena} = '0;
        rxd        = '0;
        base_addr  = '0;
        addr_model = '0;
        fd = $fopen("rx_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open rx_vectors.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            while ($fgets(text, fd)) begin
                if (text.len() > 2 && text[0] != "#") begin
                    n_read = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h",
                                     f[0], f[1], f[2], f[3], f[4],
                                     f[5], f[6], f[7], f[8], f[9]);
                    if (n_read != 10) begin
                        other_errs++;
                        $display("Vector line has %0d fields instead of 10", n_read);
                    end else begin
                        v_kind.push_back(f[0]);
                        v_len.push_back(f[1]);
                        v_dtype.push_back(f[2]);
                        v_chan.push_back(f[3]);
                        v_fend.push_back(f[4]);
                        v_line.push_back(f[5]);
                        v_flags.push_back(f[6]);
                        v_ck.push_back(f[7]);
                        v_bytes.push_back(f[8]);
                        v_pulses.push_back(f[9]);
                    end
                end
            end
            $fclose(fd);
        end
    end

    initial begin
        #1;
        limit = 200;
        foreach (v_kind[i]) begin
            // Only frames and bursts carry a length in cycles
            if (v_kind[i] < 2) begin
                limit = limit + v_len[i];
            end
            limit = limit + 300;
        end
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not complete", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        repeat (4) @(negedge clk);
        check_ctrl_low("during reset");
        wait (arst_n);
        foreach (v_kind[i]) begin
            case (v_kind[i])
                0: run_frame(i);
                1: run_link_burst(i);
                2: begin
                    @(posedge clk);
                    rx_start  <= 1'b1;
                    base_addr <= v_len[i];
                    @(posedge clk) rx_start <= 1'b0;
                    addr_model = v_len[i];
                end
                default: soft_reset_mid_frame();
            endcase
        end
        repeat (10) @(posedge clk);
        $display("Closing: %0d value errors, %0d other errors", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 20.0,
    parameter int  RST_CYCLES = 8
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

    // Release away from the rising edge
    initial begin
        o_arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;
    end

endmodule

// File: tlk2711_rx_link.sv
`timescale 1ns/1ps

module tlk2711_rx_link #(
    parameter logic [23:0] HOLDOFF_CYCLES = rx_link_pkg::LOSS_HOLDOFF_CYCLES
) (
    input  logic                                         clk,
    input  logic                                         i_arst_n,
    input  logic                                         i_soft_rst,
    input  logic                                         i_rk_msb,
    input  logic                                         i_rk_lsb,
    input  logic [rx_link_pkg::WORD_W-1:0]               i_rxd,
    input  logic                                         i_rx_start,
    input  logic [rx_link_pkg::ADDR_W-1:0]               i_rx_base_addr,
    input  logic                                         i_wr_cmd_ack,
    input  logic                                         i_dma_wr_ready,
    input  logic                                         i_wr_finish,
    input  logic                                         i_link_loss_detect_ena,
    input  logic                                         i_sync_loss_detect_ena,
    output logic                                         o_wr_cmd_req,
    output logic [rx_link_pkg::ADDR_W+rx_link_pkg::DLEN_W-1:0] o_wr_cmd_data,
    output logic                                         o_dma_wr_valid,
    output logic [rx_link_pkg::BEAT_W-1:0]               o_dma_wr_data,
    output logic                                         o_rx_interrupt,
    output logic [15:0]                                  o_rx_frame_length,
    output logic [23:0]                                  o_rx_frame_num,
    output logic [3:0]                                   o_rx_data_type,
    output logic                                         o_rx_file_end_flag,
    output logic                                         o_rx_checksum_flag,
    output logic [1:0]                                   o_rx_channel_id,
    output logic                                         o_link_loss,
    output logic                                         o_sync_loss,
    output logic                                         o_loss_interrupt
);

    logic        fifo_wr;
    logic [15:0] fifo_din;
    logic        len_valid;
    logic        frame_end;
    logic        frame_end1;
    logic        in_payload;

    rx_frame_parser u_parser (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_soft_rst      (i_soft_rst),
        .i_rk_msb        (i_rk_msb),
        .i_rk_lsb        (i_rk_lsb),
        .i_rxd           (i_rxd),
        .o_fifo_wr       (fifo_wr),
        .o_fifo_din      (fifo_din),
        .o_len_valid     (len_valid),
        .o_frame_len     (o_rx_frame_length),
        .o_frame_end     (frame_end),
        .o_frame_end1    (frame_end1),
        .o_in_payload    (in_payload),
        .o_frame_num     (o_rx_frame_num),
        .o_data_type     (o_rx_data_type),
        .o_file_end_flag (o_rx_file_end_flag),
        .o_channel_id    (o_rx_channel_id),
        .o_checksum_err  (o_rx_checksum_flag)
    );

    rx_pack_fifo u_fifo (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_soft_rst     (i_soft_rst),
        .i_wr           (fifo_wr),
        .i_din          (fifo_din),
        .i_dma_wr_ready (i_dma_wr_ready),
        .o_dma_wr_valid (o_dma_wr_valid),
        .o_dout         (o_dma_wr_data)
    );

    rx_dma_ctrl u_dma_ctrl (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_soft_rst     (i_soft_rst),
        .i_len_valid    (len_valid),
        .i_frame_len    (o_rx_frame_length),
        .i_frame_end    (frame_end),
        .i_frame_end1   (frame_end1),
        .i_rx_start     (i_rx_start),
        .i_rx_base_addr (i_rx_base_addr),
        .i_wr_cmd_ack   (i_wr_cmd_ack),
        .i_wr_finish    (i_wr_finish),
        .o_wr_cmd_req   (o_wr_cmd_req),
        .o_wr_cmd_data  (o_wr_cmd_data),
        .o_rx_interrupt (o_rx_interrupt)
    );

    rx_loss_monitor #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_loss_monitor (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_soft_rst       (i_soft_rst),
        .i_rk_msb         (i_rk_msb),
        .i_rk_lsb         (i_rk_lsb),
        .i_rxd            (i_rxd),
        .i_in_payload     (in_payload),
        .i_link_ena       (i_link_loss_detect_ena),
        .i_sync_ena       (i_sync_loss_detect_ena),
        .o_link_loss      (o_link_loss),
        .o_sync_loss      (o_sync_loss),
        .o_loss_interrupt (o_loss_interrupt)
    );

endmodule

// File: rx_loss_monitor.sv
`timescale 1ns/1ps

module rx_loss_monitor #(
    parameter logic [23:0] HOLDOFF_CYCLES = rx_link_pkg::LOSS_HOLDOFF_CYCLES
) (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_soft_rst,
    input  logic        i_rk_msb,
    input  logic        i_rk_lsb,
    input  logic [15:0] i_rxd,
    input  logic        i_in_payload,
    input  logic        i_link_ena,
    input  logic        i_sync_ena,
    output logic        o_link_loss,
    output logic        o_sync_loss,
    output logic        o_loss_interrupt
);

    import rx_link_pkg::*;

    logic [1:0] hit;
    logic [1:0] ena;
    logic [1:0] pulse;

    // Index 0 is link loss, index 1 is sync loss
    assign hit[0] = i_rk_msb && i_rk_lsb && i_rxd == LINK_LOSS_WORD;
    assign hit[1] = (i_rk_msb || i_rk_lsb) && i_in_payload;
    assign ena    = {i_sync_ena, i_link_ena};

    for (genvar i = 0; i < 2; i++) begin : g_det
        logic        pulse_q;
        logic        hold_q;
        logic [23:0] timer_q;

        always_ff @(posedge clk or negedge i_arst_n) begin
            if (!i_arst_n) begin
                pulse_q <= 1'b0;
                hold_q  <= 1'b0;
                timer_q <= '0;
            end else if (i_soft_rst || !ena[i]) begin
                pulse_q <= 1'b0;
                hold_q  <= 1'b0;
                timer_q <= '0;
            end else begin
                pulse_q <= hit[i] && !hold_q;
                if (hit[i] && !hold_q) begin
                    hold_q  <= 1'b1;
                    timer_q <= '0;
                end else if (hold_q) begin
                    // Keep the host from an interrupt storm
                    if (timer_q == HOLDOFF_CYCLES - 24'd1) begin
                        hold_q <= 1'b0;
                    end
                    timer_q <= timer_q + 24'd1;
                end
            end
        end

        assign pulse[i] = pulse_q;

        // Hold-off window never runs past its length
        a_holdoff: assert property (@(posedge clk) disable iff (!i_arst_n)
            hold_q |-> timer_q < HOLDOFF_CYCLES);
    end

    assign o_link_loss      = pulse[0];
    assign o_sync_loss      = pulse[1];
    assign o_loss_interrupt = |pulse;

endmodule

// File: rx_dma_ctrl.sv
`timescale 1ns/1ps

module rx_dma_ctrl (
    input  logic                             clk,
    input  logic                             i_arst_n,
    input  logic                             i_soft_rst,
    input  logic                             i_len_valid,
    input  logic [15:0]                      i_frame_len,
    input  logic                             i_frame_end,
    input  logic                             i_frame_end1,
    input  logic                             i_rx_start,
    input  logic [rx_link_pkg::ADDR_W-1:0]   i_rx_base_addr,
    input  logic                             i_wr_cmd_ack,
    input  logic                             i_wr_finish,
    output logic                             o_wr_cmd_req,
    output logic [rx_link_pkg::ADDR_W+rx_link_pkg::DLEN_W-1:0] o_wr_cmd_data,
    output logic                             o_rx_interrupt
);

    import rx_link_pkg::*;

    logic [ADDR_W-1:0] wr_addr;
    logic [DLEN_W-1:0] byte_cnt;
    logic              frame_done;

    // DDR writes go in 8-byte units, so round the length up
    assign byte_cnt = {i_frame_len[15:3] + 13'(|i_frame_len[2:0]), 3'b000};

    assign o_wr_cmd_data  = {wr_addr, byte_cnt};
    assign o_rx_interrupt = frame_done && i_wr_finish;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wr_cmd_req <= 1'b0;
            wr_addr      <= '0;
            frame_done   <= 1'b0;
        end else if (i_soft_rst) begin
            o_wr_cmd_req <= 1'b0;
            wr_addr      <= '0;
            frame_done   <= 1'b0;
        end else begin
            if (i_len_valid) begin
                o_wr_cmd_req <= 1'b1;
            end else if (i_wr_cmd_ack) begin
                o_wr_cmd_req <= 1'b0;
            end
            // Next frame lands right after this one
            if (i_rx_start) begin
                wr_addr <= i_rx_base_addr;
            end else if (i_frame_end) begin
                wr_addr <= wr_addr + ADDR_W'(byte_cnt);
            end
            if (i_frame_end1) begin
                frame_done <= 1'b1;
            end else if (i_wr_finish) begin
                frame_done <= 1'b0;
            end
        end
    end

endmodule

// File: rx_pack_fifo.sv
`timescale 1ns/1ps

module rx_pack_fifo (
    input  logic                           clk,
    input  logic                           i_arst_n,
    input  logic                           i_soft_rst,
    input  logic                           i_wr,
    input  logic [15:0]                    i_din,
    input  logic                           i_dma_wr_ready,
    output logic                           o_dma_wr_valid,
    output logic [rx_link_pkg::BEAT_W-1:0] o_dout
);

    import rx_link_pkg::*;

    localparam int DEPTH = FIFO_WORDS / 4;
    localparam int AW    = $clog2(DEPTH);

    logic [BEAT_W-1:0] mem [DEPTH];
    logic [2:0][15:0]  lane;
    logic [1:0]        lane_cnt;
    logic [AW:0]       wptr;
    logic [AW:0]       rptr;
    logic              push;
    logic              empty;
    logic              full;

    // Fourth word of a group completes a beat
    assign push  = i_wr && lane_cnt == 2'd3;
    assign empty = (wptr == rptr);
    assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

    assign o_dma_wr_valid = !empty && i_dma_wr_ready;
    assign o_dout         = mem[rptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (i_wr && lane_cnt != 2'd3) begin
            lane[lane_cnt] <= i_din;
        end
        if (push && !full) begin
            mem[wptr[AW-1:0]] <= {i_din, lane[2], lane[1], lane[0]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and lane position
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lane_cnt <= '0;
            wptr     <= '0;
            rptr     <= '0;
        end else if (i_soft_rst) begin
            lane_cnt <= '0;
            wptr     <= '0;
            rptr     <= '0;
        end else begin
            if (i_wr) begin
                lane_cnt <= lane_cnt + 2'd1;
            end
            if (push && !full) begin
                wptr <= wptr + 1'b1;
            end
            if (o_dma_wr_valid) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    // DMA too slow for the line rate, a beat is dropped
    a_no_overflow: assert property (@(posedge clk) disable iff (!i_arst_n)
        push |-> !full);

endmodule

// File: rx_frame_parser.sv
`timescale 1ns/1ps

module rx_frame_parser (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_soft_rst,
    input  logic        i_rk_msb,
    input  logic        i_rk_lsb,
    input  logic [15:0] i_rxd,
    output logic        o_fifo_wr,
    output logic [15:0] o_fifo_din,
    output logic        o_len_valid,
    output logic [15:0] o_frame_len,
    output logic        o_frame_end,
    output logic        o_frame_end1,
    output logic        o_in_payload,
    output logic [23:0] o_frame_num,
    output logic [3:0]  o_data_type,
    output logic        o_file_end_flag,
    output logic [1:0]  o_channel_id,
    output logic        o_checksum_err
);

    import rx_link_pkg::*;

    logic [3:0]    cs;
    logic [3:0]    ns;
    logic [15:0]   rxd_q;
    logic [14:0]   data_cnt;
    logic [1:0]    pad_cnt;
    logic [15:0]   sum;
    rx_info_word_u info;

    assign info = i_rxd;

    ////////////////////////////////////////////////////////////////////////////
    // Frame state machine
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        ns = cs;
        case (cs)
            ST_IDLE: begin
                if (!i_rk_msb && i_rk_lsb && i_rxd == {D5_6, K28_5}) begin
                    ns = ST_SYNC;
                end
            end
            ST_SYNC: begin
                if (i_rk_msb && i_rk_lsb && i_rxd == {K28_2, K27_7}) begin
                    ns = ST_HEAD;
                end
            end
            ST_HEAD: begin
                // Flag spans two words, high half first
                if ({rxd_q, i_rxd} == FRAME_HEAD_FLAG) begin
                    ns = ST_TYPE;
                end
            end
            ST_TYPE:  ns = ST_LINE;
            ST_LINE:  ns = ST_LEN;
            ST_LEN:   ns = ST_DATA;
            ST_DATA: begin
                if (data_cnt == o_frame_len[15:1] - 15'd1) begin
                    ns = ST_CHECK;
                end
            end
            ST_CHECK: ns = ST_END1;
            ST_END1:  ns = ST_END2;
            default:  ns = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cs <= ST_IDLE;
        end else if (i_soft_rst) begin
            cs <= ST_IDLE;
        end else begin
            cs <= ns;
        end
    end

    // Previous line word, also the FIFO data
    always_ff @(posedge clk) begin
        rxd_q      <= i_rxd;
        o_fifo_din <= i_rxd;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Header decode, payload count and checksum
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_frame_num     <= '0;
            o_data_type     <= '0;
            o_file_end_flag <= 1'b0;
            o_channel_id    <= '0;
            o_frame_len     <= '0;
            pad_cnt         <= '0;
            data_cnt        <= '0;
            sum             <= '0;
            o_checksum_err  <= 1'b0;
            o_fifo_wr       <= 1'b0;
            o_frame_end     <= 1'b0;
        end else if (i_soft_rst) begin
            o_frame_num     <= '0;
            o_data_type     <= '0;
            o_file_end_flag <= 1'b0;
            o_channel_id    <= '0;
            o_frame_len     <= '0;
            pad_cnt         <= '0;
            data_cnt        <= '0;
            sum             <= '0;
            o_checksum_err  <= 1'b0;
            o_fifo_wr       <= 1'b0;
            o_frame_end     <= 1'b0;
        end else begin
            if (cs == ST_TYPE) begin
                o_file_end_flag    <= info.f.file_end[0];
                o_channel_id       <= info.f.channel_id;
                o_data_type        <= info.f.data_type;
                o_frame_num[23:16] <= info.f.line_hi;
            end
            if (cs == ST_LINE) begin
                o_frame_num[15:0] <= i_rxd;
            end
            if (cs == ST_LEN) begin
                o_frame_len <= i_rxd;
                // Pad words to fill the last 64-bit beat
                pad_cnt     <= 2'b00 - i_rxd[2:1];
            end
            data_cnt <= (cs == ST_DATA) ? data_cnt + 15'd1 : '0;
            if (cs == ST_IDLE || cs == ST_SYNC || cs == ST_HEAD) begin
                sum <= '0;
            end else if (cs == ST_TYPE || cs == ST_LINE || cs == ST_LEN || cs == ST_DATA) begin
                sum <= sum + info.raw;
            end
            if (cs == ST_IDLE) begin
                o_checksum_err <= 1'b0;
            end else if (cs == ST_CHECK) begin
                o_checksum_err <= (sum != i_rxd);
            end
            o_fifo_wr <= (cs == ST_DATA) ||
                         (cs == ST_CHECK && pad_cnt != 2'd0) ||
                         (cs == ST_END1 && pad_cnt[1]) ||
                         (cs == ST_END2 && pad_cnt == 2'd3);
            o_frame_end <= (cs == ST_END1);
        end
    end

    assign o_len_valid  = (cs == ST_LEN);
    assign o_frame_end1 = (cs == ST_END1);
    assign o_in_payload = (cs >= ST_TYPE) && (cs <= ST_CHECK);

    // Payload is counted in whole words, so the length must be even and nonzero
    a_len_even: assert property (@(posedge clk) disable iff (!i_arst_n)
        (cs == ST_LEN && !i_soft_rst) |=> (!o_frame_len[0] && o_frame_len >= 16'd2));

endmodule

// File: rx_link_pkg.sv
package rx_link_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DLEN_W = 16;
    localparam int BEAT_W = 64;
    localparam int WORD_W = 16;

    // Sync word is {D5_6, K28_5}, start of frame is {K28_2, K27_7}
    localparam logic [7:0] K28_5 = 8'hbc;
    localparam logic [7:0] D5_6  = 8'hc5;
    localparam logic [7:0] K27_7 = 8'hfb;
    localparam logic [7:0] K28_2 = 8'h5c;

    localparam logic [31:0]       FRAME_HEAD_FLAG = 32'heb90_e116;
    localparam logic [WORD_W-1:0] LINK_LOSS_WORD  = 16'hffff;

    ////////////////////////////////////////////////////////////////////////////
    // Parser states
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [3:0] ST_IDLE  = 4'd0;
    localparam logic [3:0] ST_SYNC  = 4'd1;
    localparam logic [3:0] ST_HEAD  = 4'd2;
    localparam logic [3:0] ST_TYPE  = 4'd3;
    localparam logic [3:0] ST_LINE  = 4'd4;
    localparam logic [3:0] ST_LEN   = 4'd5;
    localparam logic [3:0] ST_DATA  = 4'd6;
    localparam logic [3:0] ST_CHECK = 4'd7;
    localparam logic [3:0] ST_END1  = 4'd8;
    localparam logic [3:0] ST_END2  = 4'd9;

    // Receive FIFO depth in line words
    localparam int FIFO_WORDS = 2048;

    // Quiet time after a loss pulse, about 100 ms at 100 MHz
    localparam logic [23:0] LOSS_HOLDOFF_CYCLES = 24'd10_000_000;

    // First header word, summed raw and decoded by field
    typedef union packed {
        logic [WORD_W-1:0] raw;
        struct packed {
            logic [1:0] file_end;
            logic [1:0] channel_id;
            logic [3:0] data_type;
            logic [7:0] line_hi;
        } f;
    } rx_info_word_u;

endpackage
